// File: hdl/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'b000,
        ALU_SUB    = 3'b001,
        ALU_AND    = 3'b010,
        ALU_OR     = 3'b011,
        ALU_XOR    = 3'b100,
        ALU_SLL    = 3'b101,
        ALU_SLT    = 3'b110,
        ALU_PASS_B = 3'b111   // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    typedef enum logic [1:0] {
        MEM_NONE = 2'b00,
        MEM_WORD = 2'b01,
        MEM_HALF = 2'b10,
        MEM_BYTE = 2'b11
    } mem_size_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_e;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_TARGET = 2'b01,   // pc + imm
        PC_ALU    = 2'b10    // jalr
    } pc_src_e;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // instruction field positions
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int SUB_BIT    = 30;   // funct7 bit picking sub over add
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

endpackage

// File: hdl/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;
    import cpu_pkg::*;

    logic        reg_write;
    mem_size_e   load_size;
    mem_size_e   store_size;
    result_src_e result_src;
    alu_op_e     alu_op;
    logic        alu_src;      // 1 selects the immediate
    imm_src_e    imm_src;
    pc_src_e     pc_src;

    modport control (
        output reg_write, load_size, store_size, result_src,
        output alu_op, alu_src, imm_src, pc_src
    );

    modport datapath (
        input reg_write, load_size, store_size, result_src,
        input alu_op, alu_src, imm_src, pc_src
    );

endinterface

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  cpu_pkg::pc_src_e  pc_src_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [XLEN-1:0]   alu_result_i,
    output logic [XLEN-1:0]   pc_o,
    output logic [XLEN-1:0]   pc_plus4_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_q + XLEN'(4);
    assign pc_target  = pc_q + imm_i;   // branches and jal

    always_comb
    begin
        case (pc_src_i)
            PC_TARGET: pc_next = pc_target;
            PC_ALU:    pc_next = {alu_result_i[XLEN-1:1], 1'b0};   // jalr clears bit 0
            default:   pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            pc_q <= '0;
        end
        else
        begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic [31:0] instr_i,
    input  logic        zero_i,
    ctrl_if.control     ctrl
);
    import cpu_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;

    assign opcode    = instr_i[OPCODE_W-1:0];
    assign funct3    = instr_i[FUNCT3_LSB +: 3];
    assign funct7_b5 = instr_i[SUB_BIT];

    always_comb
    begin
        ctrl.reg_write  = 1'b0;       // no-op unless decoded below
        ctrl.load_size  = MEM_NONE;
        ctrl.store_size = MEM_NONE;
        ctrl.result_src = RES_ALU;
        ctrl.alu_op     = ALU_ADD;
        ctrl.alu_src    = 1'b0;
        ctrl.imm_src    = IMM_I;
        ctrl.pc_src     = PC_PLUS4;

        case (opcode)
            OP_LOAD:
            begin
                ctrl.alu_src    = 1'b1;   // rs1 + imm
                ctrl.result_src = RES_MEM;
                ctrl.reg_write  = 1'b1;
                case (funct3)
                    3'b000:  ctrl.load_size = MEM_BYTE;
                    3'b001:  ctrl.load_size = MEM_HALF;
                    3'b010:  ctrl.load_size = MEM_WORD;
                    default: ctrl.reg_write = 1'b0;   // unsigned loads not supported
                endcase
            end
            OP_STORE:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.imm_src = IMM_S;
                case (funct3)
                    3'b000:  ctrl.store_size = MEM_BYTE;
                    3'b001:  ctrl.store_size = MEM_HALF;
                    3'b010:  ctrl.store_size = MEM_WORD;
                    default: ctrl.store_size = MEM_NONE;
                endcase
            end
            OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;   // sltu, srl, sra
                endcase
            end
            OP_ITYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_BRANCH:
            begin
                ctrl.imm_src = IMM_B;
                ctrl.alu_op  = ALU_SUB;   // zero flag gives rs1 == rs2
                case (funct3)
                    3'b000:  ctrl.pc_src = zero_i ? PC_TARGET : PC_PLUS4;   // beq
                    3'b001:  ctrl.pc_src = zero_i ? PC_PLUS4 : PC_TARGET;   // bne
                    default: ctrl.pc_src = PC_PLUS4;
                endcase
            end
            OP_JAL:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.imm_src    = IMM_J;
                ctrl.result_src = RES_PC4;   // link
                ctrl.pc_src     = PC_TARGET;
            end
            OP_JALR:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = RES_PC4;
                ctrl.pc_src     = PC_ALU;
            end
            OP_LUI:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_src   = IMM_U;
                ctrl.alu_op    = ALU_PASS_B;
            end
            default:
            begin
                ctrl.reg_write = 1'b0;   // unknown opcode writes nothing
            end
        endcase
    end

endmodule

// File: hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen #(
    parameter int XLEN = 32
) (
    input  logic [31:0]       instr_i,
    input  cpu_pkg::imm_src_e imm_src_i,
    output logic [XLEN-1:0]   imm_o
);
    import cpu_pkg::*;

    logic signed [31:0] imm32;

    always_comb
    begin
        case (imm_src_i)
            IMM_S:   imm32 = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm32 = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                              instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J:   imm32 = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                              instr_i[20], instr_i[30:21], 1'b0};
            IMM_U:   imm32 = {instr_i[31:12], 12'b0};
            default: imm32 = {{20{instr_i[31]}}, instr_i[31:20]};   // I format
        endcase
    end

    assign imm_o = XLEN'(imm32);   // sign-extends for wider XLEN

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN = 32
) (
    input  logic                           clk_i,
    input  logic                           we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]                wdata_i,
    output logic [XLEN-1:0]                rdata1_o,
    output logic [XLEN-1:0]                rdata2_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i)
    begin
        if (we_i && (waddr_i != '0))   // x0 stays zero
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    input  cpu_pkg::alu_op_e op_i,
    output logic [XLEN-1:0]  result_o,
    output logic             zero_o
);
    import cpu_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt;

    assign shamt = b_i[SHAMT_W-1:0];
    assign lt    = $signed(a_i) < $signed(b_i);   // slt is signed

    always_comb
    begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt};
            ALU_PASS_B: result_o = b_i;   // lui
            default:    result_o = a_i + b_i;
        endcase
    end

    // branches compare with sub
    assign zero_o = (result_o == '0);

endmodule

// File: hdl/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int XLEN       = 32,
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    ctrl_if.datapath        ctrl,
    output logic [XLEN-1:0] rdata_o
);
    import cpu_pkg::*;

    localparam int LANES  = XLEN / 8;
    localparam int LANE_W = $clog2(LANES);
    localparam int IDX_W  = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]   mem [DMEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [LANE_W-1:0] lane;
    logic [LANES-1:0]  byte_en;
    logic [XLEN-1:0]   wdata_rep;
    logic [XLEN-1:0]   word;
    logic [7:0]        byte_val;
    logic [15:0]       half_val;

    assign idx  = addr_i[LANE_W +: IDX_W];   // wraps modulo the depth
    assign lane = addr_i[LANE_W-1:0];

    always_comb
    begin
        byte_en   = '0;
        wdata_rep = wdata_i;
        case (ctrl.store_size)
            MEM_BYTE:
            begin
                byte_en[lane] = 1'b1;
                wdata_rep     = {LANES{wdata_i[7:0]}};
            end
            MEM_HALF:
            begin
                byte_en[{lane[LANE_W-1:1], 1'b0} +: 2] = 2'b11;   // aligned halves only
                wdata_rep = {(LANES/2){wdata_i[15:0]}};
            end
            MEM_WORD: byte_en = '1;
            default:  byte_en = '0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!reset_i)
        begin
            for (int b = 0; b < LANES; b++)
            begin
                if (byte_en[b])
                begin
                    mem[idx][8*b +: 8] <= wdata_rep[8*b +: 8];
                end
            end
        end
    end

    assign word     = mem[idx];
    assign byte_val = word[{lane, 3'b000} +: 8];
    assign half_val = word[{lane[LANE_W-1:1], 4'b0000} +: 16];

    always_comb
    begin
        case (ctrl.load_size)
            MEM_BYTE: rdata_o = XLEN'($signed(byte_val));
            MEM_HALF: rdata_o = XLEN'($signed(half_val));
            MEM_WORD: rdata_o = word;
            default:  rdata_o = '0;
        endcase
    end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
    parameter int XLEN       = 32,
    parameter int DMEM_WORDS = 256
) (
    input  logic                           clk_i,
    input  logic                           reset_i,
    output logic [XLEN-1:0]                imem_addr_o,
    input  logic [31:0]                    imem_data_i,
    output logic [XLEN-1:0]                pc_o,
    output logic                           rf_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]                rf_wdata_o,
    output logic                           dmem_we_o,
    output logic [XLEN-1:0]                dmem_addr_o,
    output logic [XLEN-1:0]                dmem_wdata_o,
    output cpu_pkg::mem_size_e             dmem_size_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;
    logic                  zero;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       wb_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    ctrl_if ctrl_bus ();

    assign rs1 = imem_data_i[RS1_LSB +: REG_ADDR_W];
    assign rs2 = imem_data_i[RS2_LSB +: REG_ADDR_W];
    assign rd  = imem_data_i[RD_LSB +: REG_ADDR_W];

    fetch_unit #(.XLEN(XLEN)) fetch_unit_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pc_src_i     (ctrl_bus.pc_src),
        .imm_i        (imm),
        .alu_result_i (alu_result),
        .pc_o         (pc),
        .pc_plus4_o   (pc_plus4)
    );

    control_unit control_unit_inst (
        .instr_i (imem_data_i),
        .zero_i  (zero),
        .ctrl    (ctrl_bus.control)
    );

    imm_gen #(.XLEN(XLEN)) imm_gen_inst (
        .instr_i   (imem_data_i),
        .imm_src_i (ctrl_bus.imm_src),
        .imm_o     (imm)
    );

    reg_file #(.XLEN(XLEN)) reg_file_inst (
        .clk_i    (clk_i),
        .we_i     (rf_we),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .waddr_i  (rd),
        .wdata_i  (wb_data),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    assign alu_b = ctrl_bus.alu_src ? imm : rdata2;

    alu #(.XLEN(XLEN)) alu_inst (
        .a_i      (rdata1),
        .b_i      (alu_b),
        .op_i     (ctrl_bus.alu_op),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    data_memory #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) data_memory_inst (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .addr_i  (alu_result),
        .wdata_i (rdata2),
        .ctrl    (ctrl_bus.datapath),
        .rdata_o (load_data)
    );

    always_comb
    begin
        case (ctrl_bus.result_src)
            RES_MEM: wb_data = load_data;
            RES_PC4: wb_data = pc_plus4;   // jal / jalr link
            default: wb_data = alu_result;
        endcase
    end

    assign rf_we = ctrl_bus.reg_write && !reset_i;   // no writeback while in reset

    assign imem_addr_o  = pc;
    assign pc_o         = pc;
    assign rf_we_o      = rf_we;
    assign rf_waddr_o   = rd;
    assign rf_wdata_o   = wb_data;
    assign dmem_we_o    = (ctrl_bus.store_size != MEM_NONE) && !reset_i;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rdata2;
    assign dmem_size_o  = ctrl_bus.store_size;

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import cpu_pkg::*;

    localparam int XLEN         = 32;
    localparam int DMEM_WORDS   = 256;
    localparam int DMEM_BYTES   = 4 * DMEM_WORDS;
    localparam int MA_W         = $clog2(DMEM_BYTES);
    localparam int PROG_LEN     = 48;
    localparam int N_PROGS      = 10;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT      = N_PROGS * (PROG_LEN + RESET_CYCLES + 10);
    localparam int WIN_BITS     = 6;   // loads and stores stay in the low 64 bytes
    localparam logic [31:0] NOP         = 32'h0000_0013;
    localparam logic [31:0] JAL_SELF    = 32'h0000_006f;   // jal x0, 0
    localparam logic [31:0] RESET_STORE = 32'h0000_2023;   // sw x0, 0(x0)
    localparam logic [31:0] FINAL_PC    = 32'(4 * (PROG_LEN - 1));
    localparam logic [2:0]  F3_TAB [7] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd6, 3'd7};

    logic              clk_i = 1'b0;
    logic              reset_i;
    logic [XLEN-1:0]   imem_addr_o;
    logic [31:0]       imem_data_i;
    logic [XLEN-1:0]   pc_o;
    logic              rf_we_o;
    logic [4:0]        rf_waddr_o;
    logic [XLEN-1:0]   rf_wdata_o;
    logic              dmem_we_o;
    logic [XLEN-1:0]   dmem_addr_o;
    logic [XLEN-1:0]   dmem_wdata_o;
    mem_size_e         dmem_size_o;

    logic [31:0] imem [64];
    bit          gen_ok [64];          // slot already generated
    logic [31:0] m_regs [32];
    bit          reg_ok [32];          // register holds a known value
    logic [7:0]  m_mem [DMEM_BYTES];
    bit          mem_ok [DMEM_BYTES];
    logic [31:0] m_pc;
    logic [31:0] lfsr = 32'hee43;
    string       test_name;
    int          error_count = 0;
    int          cycle_count = 0;

    always #4 clk_i = ~clk_i;

    assign imem_data_i = imem[imem_addr_o[7:2]];   // same-cycle instruction memory read

    rv_core_top #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) rv_core_top_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .pc_o         (pc_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .rf_wdata_o   (rf_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_size_o  (dmem_size_o)
    );

    always @(posedge clk_i)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT)
        begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_bits(8)) % n;
    endfunction

    function automatic logic [4:0] pick_src();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        return reg_ok[r] ? r : 5'd0;   // unknown registers fall back to x0
    endfunction

    task automatic stop_on_error();
        error_count++;
        $display("=== FAIL ===");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input string what, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp)
        begin
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_reg_idx(input string what, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp)
        begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_size(input string what, input mem_size_e exp, input mem_size_e act);
        if (act !== exp)
        begin
            $display("error %s %s: expected %s, actual %s", test_name, what,
                     exp.name(), act.name());
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    // builds slot k when pc first reaches it, so sources are always known
    task automatic gen_slot(input int k);
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [1:0]  sz;
        logic [31:0] addr;
        logic        ok;
        int          sel;
        int          t;
        kind = 4'(rand_bits(4));
        rd   = 5'(rand_bits(5));
        rs1  = pick_src();
        rs2  = pick_src();
        imm  = 12'(rand_bits(12));
        sz   = 2'(rand_below(3));
        addr = rand_bits(WIN_BITS) & ~((32'd1 << sz) - 32'd1);
        ok   = 1'b1;
        for (int i = 0; i < (1 << sz); i++)
        begin
            ok = ok && mem_ok[MA_W'(addr + 32'(i))];
        end
        if (kind == 4'd14 && k > PROG_LEN - 4)
        begin
            kind = 4'd0;   // no room for the addi and jalr pair
        end
        t = k + 1 + rand_below(PROG_LEN - 1 - k);   // forward and inside the program
        case (kind)
            4'd0, 4'd1, 4'd2:
            begin
                sel = rand_below(7);
                imem[6'(k)] = {1'b0, sel == 1, 5'b0, rs2, rs1, F3_TAB[sel], rd, OP_RTYPE};
            end
            4'd3, 4'd4, 4'd5, 4'd15:
            begin
                sel = 1 + rand_below(6);
                if (F3_TAB[sel] == 3'd1)
                begin
                    imm = {7'b0, imm[4:0]};   // slli
                end
                if (kind == 4'd15)
                begin
                    rd = 5'd0;
                end
                imem[6'(k)] = {imm, rs1, F3_TAB[sel], rd, OP_ITYPE};
            end
            4'd6: imem[6'(k)] = {20'(rand_bits(20)), rd, OP_LUI};
            4'd7, 4'd8, 4'd9, 4'd10:
            begin
                if (kind >= 4'd9 && ok)
                begin
                    imem[6'(k)] = {addr[11:0], 5'd0, 1'b0, sz, rd, OP_LOAD};
                end
                else
                begin
                    imem[6'(k)] = {addr[11:5], rs2, 5'd0, 1'b0, sz, addr[4:0], OP_STORE};
                end
            end
            4'd11, 4'd12:
            begin
                addr = 32'((t - k) * 4);
                if (rand_bits(1) == 32'd1)
                begin
                    rs2 = rs1;   // equal operands
                end
                imem[6'(k)] = {addr[12], addr[10:5], rs2, rs1, 2'b00, kind == 4'd12,
                               addr[4:1], addr[11], OP_BRANCH};
            end
            4'd13:
            begin
                addr = 32'((t - k) * 4);
                imem[6'(k)] = {addr[20], addr[10:1], addr[11], addr[19:12], rd, OP_JAL};
            end
            default:
            begin
                t   = k + 2 + rand_below(PROG_LEN - 2 - k);
                rs1 = 5'(rand_bits(5)) | 5'd1;   // base register is never x0
                imem[6'(k)]     = {12'(t * 4), 5'd0, 3'b000, rs1, OP_ITYPE};
                imem[6'(k + 1)] = {11'd0, 1'(rand_bits(1)), rs1, 3'b000, rd, OP_JALR};
                gen_ok[6'(k + 1)] = 1'b1;
            end
        endcase
        gen_ok[6'(k)] = 1'b1;
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] x,
                                            input logic [31:0] y, input logic sub);
        logic [31:0] r;
        case (f3)
            3'd0:    r = sub ? x - y : x + y;
            3'd1:    r = x << y[4:0];
            3'd2:    r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd4:    r = x ^ y;
            3'd6:    r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return m_mem[a[MA_W-1:0]];
    endfunction

    // executes the instruction at m_pc by the ISA rules, checks the ports, then commits
    task automatic execute_and_check();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] ea;
        logic [31:0] wdata;
        logic [31:0] next_pc;
        logic [7:0]  lb0;
        logic [7:0]  lb1;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        exp_we;
        logic        exp_dwe;
        mem_size_e   exp_size;
        instr    = imem[m_pc[7:2]];
        rd       = instr[11:7];
        f3       = instr[14:12];
        a        = m_regs[instr[19:15]];
        b        = m_regs[instr[24:20]];
        imm_i    = {{20{instr[31]}}, instr[31:20]};
        ea       = a + imm_i;
        wdata    = '0;
        next_pc  = m_pc + 32'd4;
        exp_we   = 1'b0;
        exp_dwe  = 1'b0;
        exp_size = MEM_NONE;
        case (instr[6:0])
            OP_RTYPE:
            begin
                exp_we = 1'b1;
                wdata  = alu_ref(f3, a, b, instr[30]);
            end
            OP_ITYPE:
            begin
                exp_we = 1'b1;
                wdata  = alu_ref(f3, a, imm_i, 1'b0);
            end
            OP_LUI:
            begin
                exp_we = 1'b1;
                wdata  = {instr[31:12], 12'b0};
            end
            OP_LOAD:
            begin
                exp_we = 1'b1;
                lb0    = mem_byte(ea);
                lb1    = mem_byte(ea + 32'd1);
                case (f3)
                    3'd0:    wdata = {{24{lb0[7]}}, lb0};
                    3'd1:    wdata = {{16{lb1[7]}}, lb1, lb0};
                    default: wdata = {mem_byte(ea + 32'd3), mem_byte(ea + 32'd2), lb1, lb0};
                endcase
            end
            OP_STORE:
            begin
                exp_dwe = 1'b1;
                ea      = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                case (f3)
                    3'd0:    exp_size = MEM_BYTE;
                    3'd1:    exp_size = MEM_HALF;
                    default: exp_size = MEM_WORD;
                endcase
            end
            OP_BRANCH:
            begin
                if ((a == b) != f3[0])   // beq taken on equal, bne on not equal
                begin
                    next_pc = m_pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                      instr[11:8], 1'b0};
                end
            end
            OP_JAL:
            begin
                exp_we  = 1'b1;
                wdata   = m_pc + 32'd4;
                next_pc = m_pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            end
            OP_JALR:
            begin
                exp_we  = 1'b1;
                wdata   = m_pc + 32'd4;
                next_pc = ea & ~32'd1;
            end
            default: exp_we = 1'b0;
        endcase
        check_word("pc", m_pc, pc_o);
        check_word("imem_addr", m_pc, imem_addr_o);
        check_flag("rf_we", exp_we, rf_we_o);
        if (exp_we)
        begin
            check_reg_idx("rf_waddr", rd, rf_waddr_o);
            check_word("rf_wdata", wdata, rf_wdata_o);
        end
        check_flag("dmem_we", exp_dwe, dmem_we_o);
        check_size("dmem_size", exp_size, dmem_size_o);
        if (exp_dwe)
        begin
            check_word("dmem_addr", ea, dmem_addr_o);
            check_word("dmem_wdata", b, dmem_wdata_o);
            for (int i = 0; i < (1 << f3); i++)   // little endian byte lanes
            begin
                m_mem[MA_W'(ea + 32'(i))]  = b[8*i +: 8];
                mem_ok[MA_W'(ea + 32'(i))] = 1'b1;
            end
        end
        if (exp_we && rd != 5'd0)
        begin
            m_regs[rd] = wdata;
            reg_ok[rd] = 1'b1;
        end
        m_pc = next_pc;
    endtask

    task automatic apply_reset();
        test_name = "reset";
        @(posedge clk_i);
        reset_i <= 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(negedge clk_i);
            check_flag("rf_we", 1'b0, rf_we_o);
            check_flag("dmem_we", 1'b0, dmem_we_o);
            if (i > 0)
            begin
                check_word("pc", '0, pc_o);
            end
            @(posedge clk_i);
        end
        reset_i <= 1'b0;
    endtask

    task automatic run_program(input int p);
        for (int i = 0; i < 64; i++)
        begin
            imem[i]   = NOP;
            gen_ok[i] = 1'b0;
        end
        imem[PROG_LEN-1]   = JAL_SELF;
        gen_ok[PROG_LEN-1] = 1'b1;
        if (p % 2 == 1)
        begin
            imem[0] = RESET_STORE;   // store sits at the reset pc while reset is high
        end
        apply_reset();
        m_pc = '0;
        while (m_pc != FINAL_PC)
        begin
            if (!gen_ok[m_pc[7:2]])
            begin
                gen_slot(int'(m_pc[7:2]));
            end
            test_name = $sformatf("prog %0d pc %h", p, m_pc);
            @(negedge clk_i);
            execute_and_check();
        end
        test_name = $sformatf("prog %0d final jal", p);
        @(negedge clk_i);
        execute_and_check();
        @(negedge clk_i);
        check_word("pc_hold", m_pc, pc_o);   // jal to itself keeps pc
    endtask

    initial
    begin
        reset_i = 1'b1;
        for (int i = 0; i < 32; i++)
        begin
            m_regs[i] = '0;
            reg_ok[i] = (i == 0);   // only x0 is known before the first run
        end
        for (int i = 0; i < DMEM_BYTES; i++)
        begin
            m_mem[i]  = '0;
            mem_ok[i] = 1'b0;
        end
        for (int p = 0; p < N_PROGS; p++)
        begin
            run_program(p);
        end
        if (error_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: flist.f
hdl/cpu_pkg.sv
hdl/ctrl_if.sv
hdl/fetch_unit.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_memory.sv
hdl/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_rv_core
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
